// ==== rtl/mem_path_pkg.sv ====
package mem_path_pkg;

  // core and outside bus widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 64;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  // axi bresp / rresp
  typedef logic [1:0] resp_t;

  localparam resp_t OKAY_RESP = 2'b00;

  // cacheable window, both ends inclusive
  localparam addr_t CACHE_LO = 32'h8000_0000;
  localparam addr_t CACHE_HI = 32'h8800_0000;

  // direct-mapped geometry, one 64-bit word per line
  localparam int OFFSET_W = 3;
  localparam int INDEX_W = 4;
  localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W;
  localparam int LINES = 1 << INDEX_W;

  typedef logic [INDEX_W-1:0] index_t;
  typedef logic [TAG_W-1:0] tag_t;

  // cache controller
  typedef enum logic [1:0] {
    CACHE_IDLE,
    CACHE_LOOKUP,
    CACHE_FETCH,
    CACHE_WRITE_THRU
  } cache_state_e;

  // axi master, one transaction at a time
  typedef enum logic [1:0] {
    MST_IDLE,
    MST_ADDR_PHASE,
    MST_WAIT_B,
    MST_WAIT_R
  } master_state_e;

endpackage

// ==== rtl/mem_req_if.sv ====
// single-word request with a one-cycle response strobe
interface mem_req_if;

  // request side, valid/ready handshake
  logic                valid;
  logic                ready;
  mem_path_pkg::addr_t addr;
  logic                we;
  mem_path_pkg::data_t wdata;

  // response side, no back-pressure
  logic                rsp_valid;
  // don't-care for writes
  mem_path_pkg::data_t rdata;

  modport requester (
    output valid,
    output addr,
    output we,
    output wdata,
    input  ready,
    input  rsp_valid,
    input  rdata
  );

  modport responder (
    input  valid,
    input  addr,
    input  we,
    input  wdata,
    output ready,
    output rsp_valid,
    output rdata
  );

endinterface

// ==== rtl/uncache_router.sv ====
module uncache_router (
  input logic          clk,
  input logic          rst_n_i,
  mem_req_if.responder core,
  mem_req_if.requester cache,
  mem_req_if.responder fill,
  mem_req_if.requester mst
);

  // control
  logic busy_q;
  logic pend_q;
  logic cached_q;
  logic unc_rsp_q;
  // held request and uncached read data
  mem_path_pkg::addr_t addr_q;
  logic                we_q;
  mem_path_pkg::data_t wdata_q;
  mem_path_pkg::data_t unc_rdata_q;
  logic in_window;
  logic accept;
  logic down_take;

  // decode only matters in the accept cycle
  assign in_window = (core.addr >= mem_path_pkg::CACHE_LO) &&
                     (core.addr <= mem_path_pkg::CACHE_HI);
  assign core.ready = !busy_q;
  assign accept = core.valid && !busy_q;
  assign down_take = pend_q && (cached_q ? cache.ready : mst.ready);

  // cached route
  assign cache.valid = pend_q && cached_q;
  assign cache.addr = addr_q;
  assign cache.we = we_q;
  assign cache.wdata = wdata_q;

  // master port, owned by the cache while the route is cached
  assign mst.valid = cached_q ? fill.valid : pend_q;
  assign mst.addr = cached_q ? fill.addr : addr_q;
  assign mst.we = cached_q ? fill.we : we_q;
  assign mst.wdata = cached_q ? fill.wdata : wdata_q;
  assign fill.ready = cached_q && mst.ready;
  assign fill.rsp_valid = cached_q && mst.rsp_valid;
  assign fill.rdata = mst.rdata;

  // uncached responses come back one cycle after the master's pulse
  assign core.rsp_valid = cached_q ? cache.rsp_valid : unc_rsp_q;
  assign core.rdata = cached_q ? cache.rdata : unc_rdata_q;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
      pend_q <= 1'b0;
      cached_q <= 1'b0;
      unc_rsp_q <= 1'b0;
    end else begin
      unc_rsp_q <= !cached_q && mst.rsp_valid;
      if (accept) begin
        busy_q <= 1'b1;
        pend_q <= 1'b1;
        cached_q <= in_window;
      end else begin
        if (down_take) begin
          pend_q <= 1'b0;
        end
        // free again once the core has its answer
        if (core.rsp_valid) begin
          busy_q <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      addr_q <= core.addr;
      we_q <= core.we;
      wdata_q <= core.wdata;
    end
    if (mst.rsp_valid) begin
      unc_rdata_q <= mst.rdata;
    end
  end

  // cache registers the fill, so its answer lags the fill by a cycle
  a_rsp_not_with_fill: assert property (@(posedge clk) disable iff (!rst_n_i)
    !(core.rsp_valid && fill.rsp_valid))
    else $error("core response in the same cycle as a fill response");

endmodule

// ==== rtl/dm_cache.sv ====
module dm_cache (
  input logic          clk,
  input logic          rst_n_i,
  mem_req_if.responder up,
  mem_req_if.requester down
);

  mem_path_pkg::cache_state_e state_q;
  logic [mem_path_pkg::LINES-1:0] valid_q;
  logic down_pend_q;
  // response pending after a fill or a write-through
  logic rsp_q;

  // line storage, no reset
  mem_path_pkg::tag_t  tag_arr [mem_path_pkg::LINES];
  mem_path_pkg::data_t data_arr [mem_path_pkg::LINES];

  // request captured at accept
  mem_path_pkg::addr_t addr_q;
  logic                we_q;
  mem_path_pkg::data_t wdata_q;

  mem_path_pkg::index_t idx;
  mem_path_pkg::tag_t   tag;
  logic hit;
  logic take;
  logic fill_done;
  logic wr_hit;

  // address split
  assign idx = addr_q[mem_path_pkg::OFFSET_W +: mem_path_pkg::INDEX_W];
  assign tag = addr_q[mem_path_pkg::ADDR_W-1 -: mem_path_pkg::TAG_W];
  assign hit = valid_q[idx] && (tag_arr[idx] == tag);

  assign take = up.valid && up.ready;
  assign fill_done = (state_q == mem_path_pkg::CACHE_FETCH) && down.rsp_valid;
  assign wr_hit = (state_q == mem_path_pkg::CACHE_LOOKUP) && we_q && hit;

  assign up.ready = (state_q == mem_path_pkg::CACHE_IDLE) && !rsp_q;
  // read hit answers straight out of lookup
  assign up.rsp_valid = rsp_q || ((state_q == mem_path_pkg::CACHE_LOOKUP) && !we_q && hit);
  // after a fill the line already holds the fetched word
  assign up.rdata = data_arr[idx];

  // downstream request, fetch or write-through
  assign down.valid = down_pend_q;
  assign down.addr = addr_q;
  assign down.we = we_q;
  assign down.wdata = wdata_q;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q <= mem_path_pkg::CACHE_IDLE;
      valid_q <= '0;
      down_pend_q <= 1'b0;
      rsp_q <= 1'b0;
    end else begin
      rsp_q <= 1'b0;
      if (down.valid && down.ready) begin
        down_pend_q <= 1'b0;
      end
      case (state_q)
        mem_path_pkg::CACHE_IDLE: begin
          if (take) begin
            state_q <= mem_path_pkg::CACHE_LOOKUP;
          end
        end
        mem_path_pkg::CACHE_LOOKUP: begin
          // writes always go out, hit or miss
          if (we_q) begin
            state_q <= mem_path_pkg::CACHE_WRITE_THRU;
            down_pend_q <= 1'b1;
          end else if (hit) begin
            state_q <= mem_path_pkg::CACHE_IDLE;
          end else begin
            state_q <= mem_path_pkg::CACHE_FETCH;
            down_pend_q <= 1'b1;
          end
        end
        mem_path_pkg::CACHE_FETCH: begin
          if (down.rsp_valid) begin
            valid_q[idx] <= 1'b1;
            rsp_q <= 1'b1;
            state_q <= mem_path_pkg::CACHE_IDLE;
          end
        end
        mem_path_pkg::CACHE_WRITE_THRU: begin
          if (down.rsp_valid) begin
            rsp_q <= 1'b1;
            state_q <= mem_path_pkg::CACHE_IDLE;
          end
        end
        default: begin
          state_q <= mem_path_pkg::CACHE_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      addr_q <= up.addr;
      we_q <= up.we;
      wdata_q <= up.wdata;
    end
    // write hit refreshes the word, a write miss leaves the line alone
    if (wr_hit) begin
      data_arr[idx] <= wdata_q;
    end
    // read allocate
    if (fill_done) begin
      tag_arr[idx] <= tag;
      data_arr[idx] <= down.rdata;
    end
  end

  a_no_down_in_idle: assert property (@(posedge clk) disable iff (!rst_n_i)
    (state_q == mem_path_pkg::CACHE_IDLE) |-> !down.valid)
    else $error("cache raises a downstream request while idle");

endmodule

// ==== rtl/axi_single_master.sv ====
module axi_single_master (
  input  logic                  clk,
  input  logic                  rst_n_i,
  mem_req_if.responder          req,
  // write address
  output logic                  axi_aw_valid_o,
  input  logic                  axi_aw_ready_i,
  output mem_path_pkg::addr_t   axi_aw_addr_o,
  // write data
  output logic                  axi_w_valid_o,
  input  logic                  axi_w_ready_i,
  output mem_path_pkg::data_t   axi_w_data_o,
  // write response
  input  logic                  axi_b_valid_i,
  output logic                  axi_b_ready_o,
  input  mem_path_pkg::resp_t   axi_b_resp_i,
  // read address
  output logic                  axi_ar_valid_o,
  input  logic                  axi_ar_ready_i,
  output mem_path_pkg::addr_t   axi_ar_addr_o,
  // read data
  input  logic                  axi_r_valid_i,
  output logic                  axi_r_ready_o,
  input  mem_path_pkg::data_t   axi_r_data_i,
  input  mem_path_pkg::resp_t   axi_r_resp_i
);

  mem_path_pkg::master_state_e state_q;
  logic aw_pend_q;
  logic w_pend_q;
  mem_path_pkg::addr_t addr_q;
  mem_path_pkg::data_t wdata_q;
  logic we_q;
  logic aw_done;
  logic w_done;
  logic b_hs;
  logic r_hs;

  assign req.ready = (state_q == mem_path_pkg::MST_IDLE);

  // aw and w leave together, each drops on its own ready
  assign axi_aw_valid_o = aw_pend_q;
  assign axi_w_valid_o = w_pend_q;
  assign axi_ar_valid_o = (state_q == mem_path_pkg::MST_ADDR_PHASE) && !we_q;
  assign axi_aw_addr_o = addr_q;
  assign axi_ar_addr_o = addr_q;
  assign axi_w_data_o = wdata_q;
  assign axi_b_ready_o = (state_q == mem_path_pkg::MST_WAIT_B);
  assign axi_r_ready_o = (state_q == mem_path_pkg::MST_WAIT_R);

  // channel done if already accepted or accepted this cycle
  assign aw_done = !aw_pend_q || axi_aw_ready_i;
  assign w_done = !w_pend_q || axi_w_ready_i;
  assign b_hs = axi_b_valid_i && axi_b_ready_o;
  assign r_hs = axi_r_valid_i && axi_r_ready_o;

  // response pulse rides on the b or r handshake
  assign req.rsp_valid = b_hs || r_hs;
  assign req.rdata = axi_r_data_i;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q <= mem_path_pkg::MST_IDLE;
      aw_pend_q <= 1'b0;
      w_pend_q <= 1'b0;
    end else begin
      case (state_q)
        mem_path_pkg::MST_IDLE: begin
          if (req.valid) begin
            aw_pend_q <= req.we;
            w_pend_q <= req.we;
            state_q <= mem_path_pkg::MST_ADDR_PHASE;
          end
        end
        mem_path_pkg::MST_ADDR_PHASE: begin
          if (we_q) begin
            if (axi_aw_ready_i) begin
              aw_pend_q <= 1'b0;
            end
            if (axi_w_ready_i) begin
              w_pend_q <= 1'b0;
            end
            if (aw_done && w_done) begin
              state_q <= mem_path_pkg::MST_WAIT_B;
            end
          end else if (axi_ar_ready_i) begin
            state_q <= mem_path_pkg::MST_WAIT_R;
          end
        end
        mem_path_pkg::MST_WAIT_B: begin
          if (b_hs) begin
            state_q <= mem_path_pkg::MST_IDLE;
          end
        end
        mem_path_pkg::MST_WAIT_R: begin
          if (r_hs) begin
            state_q <= mem_path_pkg::MST_IDLE;
          end
        end
        default: begin
          state_q <= mem_path_pkg::MST_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (req.valid && req.ready) begin
      addr_q <= req.addr;
      wdata_q <= req.wdata;
      we_q <= req.we;
    end
  end

  // payload holds while a channel waits for ready
  a_aw_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
    axi_aw_valid_o && !axi_aw_ready_i |=> axi_aw_valid_o && $stable(axi_aw_addr_o))
    else $error("aw dropped or changed before ready");
  a_w_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
    axi_w_valid_o && !axi_w_ready_i |=> axi_w_valid_o && $stable(axi_w_data_o))
    else $error("w dropped or changed before ready");
  a_ar_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
    axi_ar_valid_o && !axi_ar_ready_i |=> axi_ar_valid_o && $stable(axi_ar_addr_o))
    else $error("ar dropped or changed before ready");

  a_rd_wr_apart: assert property (@(posedge clk) disable iff (!rst_n_i)
    !(axi_ar_valid_o && axi_aw_valid_o))
    else $error("read and write address issued together");

  // error responses pass through unflagged to the core
  a_resp_okay: assert property (@(posedge clk) disable iff (!rst_n_i)
    req.rsp_valid |-> (b_hs ? axi_b_resp_i : axi_r_resp_i) == mem_path_pkg::OKAY_RESP)
    else $warning("slave error response ignored");

endmodule

// ==== rtl/mem_crossbar.sv ====
module mem_crossbar (
  input  logic                clk,
  input  logic                rst_n_i,
  // core side
  input  logic                req_valid_i,
  output logic                req_ready_o,
  input  mem_path_pkg::addr_t req_addr_i,
  input  logic                req_we_i,
  input  mem_path_pkg::data_t req_wdata_i,
  output logic                rsp_valid_o,
  output mem_path_pkg::data_t rsp_rdata_o,
  // axi write
  output logic                axi_aw_valid_o,
  input  logic                axi_aw_ready_i,
  output mem_path_pkg::addr_t axi_aw_addr_o,
  output logic                axi_w_valid_o,
  input  logic                axi_w_ready_i,
  output mem_path_pkg::data_t axi_w_data_o,
  input  logic                axi_b_valid_i,
  output logic                axi_b_ready_o,
  input  mem_path_pkg::resp_t axi_b_resp_i,
  // axi read
  output logic                axi_ar_valid_o,
  input  logic                axi_ar_ready_i,
  output mem_path_pkg::addr_t axi_ar_addr_o,
  input  logic                axi_r_valid_i,
  output logic                axi_r_ready_o,
  input  mem_path_pkg::data_t axi_r_data_i,
  input  mem_path_pkg::resp_t axi_r_resp_i
);

  // core to router, router to cache, cache refill, router to master
  mem_req_if core_bus ();
  mem_req_if cache_bus ();
  mem_req_if fill_bus ();
  mem_req_if mst_bus ();

  assign core_bus.valid = req_valid_i;
  assign core_bus.addr = req_addr_i;
  assign core_bus.we = req_we_i;
  assign core_bus.wdata = req_wdata_i;
  assign req_ready_o = core_bus.ready;
  assign rsp_valid_o = core_bus.rsp_valid;
  assign rsp_rdata_o = core_bus.rdata;

  uncache_router u_router (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .core    (core_bus.responder),
    .cache   (cache_bus.requester),
    .fill    (fill_bus.responder),
    .mst     (mst_bus.requester)
  );

  dm_cache u_cache (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .up      (cache_bus.responder),
    .down    (fill_bus.requester)
  );

  axi_single_master u_master (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .req            (mst_bus.responder),
    .axi_aw_valid_o (axi_aw_valid_o),
    .axi_aw_ready_i (axi_aw_ready_i),
    .axi_aw_addr_o  (axi_aw_addr_o),
    .axi_w_valid_o  (axi_w_valid_o),
    .axi_w_ready_i  (axi_w_ready_i),
    .axi_w_data_o   (axi_w_data_o),
    .axi_b_valid_i  (axi_b_valid_i),
    .axi_b_ready_o  (axi_b_ready_o),
    .axi_b_resp_i   (axi_b_resp_i),
    .axi_ar_valid_o (axi_ar_valid_o),
    .axi_ar_ready_i (axi_ar_ready_i),
    .axi_ar_addr_o  (axi_ar_addr_o),
    .axi_r_valid_i  (axi_r_valid_i),
    .axi_r_ready_o  (axi_r_ready_o),
    .axi_r_data_i   (axi_r_data_i),
    .axi_r_resp_i   (axi_r_resp_i)
  );

endmodule

// ==== test/axi_mem_model.sv ====
module axi_mem_model (
  input  logic                clk,
  input  logic                rst_n_i,
  input  logic                aw_valid_i,
  output logic                aw_ready_o,
  input  mem_path_pkg::addr_t aw_addr_i,
  input  logic                w_valid_i,
  output logic                w_ready_o,
  input  mem_path_pkg::data_t w_data_i,
  output logic                b_valid_o,
  input  logic                b_ready_i,
  output mem_path_pkg::resp_t b_resp_o,
  input  logic                ar_valid_i,
  output logic                ar_ready_o,
  input  mem_path_pkg::addr_t ar_addr_i,
  output logic                r_valid_o,
  input  logic                r_ready_i,
  output mem_path_pkg::data_t r_data_o,
  output mem_path_pkg::resp_t r_resp_o
);

  // sparse word store, unwritten words read as zero
  mem_path_pkg::data_t mem [mem_path_pkg::addr_t];

  logic aw_rdy_q = 1'b0;
  logic w_rdy_q = 1'b0;
  logic b_vld_q = 1'b0;
  logic ar_rdy_q = 1'b0;
  logic r_vld_q = 1'b0;
  mem_path_pkg::data_t r_data_q = '0;
  // extra ready delay per channel
  int aw_wait = 0;
  int w_wait = 0;
  int ar_wait = 0;
  // write halves collected so far
  logic aw_got = 1'b0;
  logic w_got = 1'b0;
  mem_path_pkg::addr_t aw_addr_q;
  mem_path_pkg::data_t w_data_q;

  assign aw_ready_o = aw_rdy_q;
  assign w_ready_o = w_rdy_q;
  assign b_valid_o = b_vld_q;
  assign ar_ready_o = ar_rdy_q;
  assign r_valid_o = r_vld_q;
  assign r_data_o = r_data_q;
  // always okay
  assign b_resp_o = mem_path_pkg::OKAY_RESP;
  assign r_resp_o = mem_path_pkg::OKAY_RESP;

  always @(posedge clk) begin
    if (!rst_n_i) begin
      aw_rdy_q <= 1'b0;
      w_rdy_q <= 1'b0;
      b_vld_q <= 1'b0;
      aw_got <= 1'b0;
      w_got <= 1'b0;
    end else begin
      if (aw_valid_i && aw_rdy_q) begin
        aw_rdy_q <= 1'b0;
        aw_got <= 1'b1;
        aw_addr_q <= aw_addr_i;
        aw_wait <= $urandom_range(3, 0);
      end else if (aw_valid_i && !aw_got) begin
        if (aw_wait == 0) begin
          aw_rdy_q <= 1'b1;
        end else begin
          aw_wait <= aw_wait - 1;
        end
      end
      if (w_valid_i && w_rdy_q) begin
        w_rdy_q <= 1'b0;
        w_got <= 1'b1;
        w_data_q <= w_data_i;
        w_wait <= $urandom_range(3, 0);
      end else if (w_valid_i && !w_got) begin
        if (w_wait == 0) begin
          w_rdy_q <= 1'b1;
        end else begin
          w_wait <= w_wait - 1;
        end
      end
      // both halves in, commit and answer
      if (aw_got && w_got && !b_vld_q) begin
        mem[aw_addr_q] = w_data_q;
        b_vld_q <= 1'b1;
        aw_got <= 1'b0;
        w_got <= 1'b0;
      end
      if (b_vld_q && b_ready_i) begin
        b_vld_q <= 1'b0;
      end
    end
  end

  always @(posedge clk) begin
    if (!rst_n_i) begin
      ar_rdy_q <= 1'b0;
      r_vld_q <= 1'b0;
    end else begin
      if (ar_valid_i && ar_rdy_q) begin
        ar_rdy_q <= 1'b0;
        ar_wait <= $urandom_range(3, 0);
        r_vld_q <= 1'b1;
        r_data_q <= mem.exists(ar_addr_i) ? mem[ar_addr_i] : '0;
      end else if (ar_valid_i) begin
        if (ar_wait == 0) begin
          ar_rdy_q <= 1'b1;
        end else begin
          ar_wait <= ar_wait - 1;
        end
      end
      // data held until the master takes it
      if (r_vld_q && r_ready_i) begin
        r_vld_q <= 1'b0;
      end
    end
  end

endmodule

// ==== test/tb_mem_crossbar.sv ====
module tb_mem_crossbar;

  logic clk = 1'b0;
  logic rst_n_i;
  // core side
  logic                req_valid_i;
  logic                req_ready_o;
  mem_path_pkg::addr_t req_addr_i;
  logic                req_we_i;
  mem_path_pkg::data_t req_wdata_i;
  logic                rsp_valid_o;
  mem_path_pkg::data_t rsp_rdata_o;
  // axi between dut and memory model
  logic                axi_aw_valid_o;
  logic                axi_aw_ready_i;
  mem_path_pkg::addr_t axi_aw_addr_o;
  logic                axi_w_valid_o;
  logic                axi_w_ready_i;
  mem_path_pkg::data_t axi_w_data_o;
  logic                axi_b_valid_i;
  logic                axi_b_ready_o;
  mem_path_pkg::resp_t axi_b_resp_i;
  logic                axi_ar_valid_o;
  logic                axi_ar_ready_i;
  mem_path_pkg::addr_t axi_ar_addr_o;
  logic                axi_r_valid_i;
  logic                axi_r_ready_o;
  mem_path_pkg::data_t axi_r_data_i;
  mem_path_pkg::resp_t axi_r_resp_i;

  int cyc;
  int issued;
  int check_errors;
  int proto_errors;
  // axi handshakes seen so far
  int ar_seen;
  int aw_seen;
  int w_seen;
  mem_path_pkg::addr_t ar_addr_seen;
  mem_path_pkg::addr_t aw_addr_seen;
  mem_path_pkg::data_t w_data_seen;
  logic outstanding;
  // reference copy of the outside memory
  mem_path_pkg::data_t ref_mem [mem_path_pkg::addr_t];

  always #5 clk = ~clk;

  mem_crossbar u_dut (.*);

  axi_mem_model u_mem (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .aw_valid_i (axi_aw_valid_o),
    .aw_ready_o (axi_aw_ready_i),
    .aw_addr_i  (axi_aw_addr_o),
    .w_valid_i  (axi_w_valid_o),
    .w_ready_o  (axi_w_ready_i),
    .w_data_i   (axi_w_data_o),
    .b_valid_o  (axi_b_valid_i),
    .b_ready_i  (axi_b_ready_o),
    .b_resp_o   (axi_b_resp_i),
    .ar_valid_i (axi_ar_valid_o),
    .ar_ready_o (axi_ar_ready_i),
    .ar_addr_i  (axi_ar_addr_o),
    .r_valid_o  (axi_r_valid_i),
    .r_ready_i  (axi_r_ready_o),
    .r_data_o   (axi_r_data_i),
    .r_resp_o   (axi_r_resp_i)
  );

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (axi_ar_valid_o && axi_ar_ready_i) begin
      ar_seen <= ar_seen + 1;
      ar_addr_seen <= axi_ar_addr_o;
    end
    if (axi_aw_valid_o && axi_aw_ready_i) begin
      aw_seen <= aw_seen + 1;
      aw_addr_seen <= axi_aw_addr_o;
    end
    if (axi_w_valid_o && axi_w_ready_i) begin
      w_seen <= w_seen + 1;
      w_data_seen <= axi_w_data_o;
    end
    // one request between accept and response
    if (!rst_n_i) begin
      outstanding <= 1'b0;
    end else if (req_valid_i && req_ready_o) begin
      outstanding <= 1'b1;
    end else if (rsp_valid_o) begin
      outstanding <= 1'b0;
    end
  end

  // axi payload held until ready
  assert property (@(posedge clk) disable iff (!rst_n_i)
    axi_aw_valid_o && !axi_aw_ready_i |=> axi_aw_valid_o && $stable(axi_aw_addr_o))
    else begin
      proto_errors++;
      $display("aw valid dropped or address changed before ready at cycle %0d", cyc);
    end
  assert property (@(posedge clk) disable iff (!rst_n_i)
    axi_w_valid_o && !axi_w_ready_i |=> axi_w_valid_o && $stable(axi_w_data_o))
    else begin
      proto_errors++;
      $display("w valid dropped or data changed before ready at cycle %0d", cyc);
    end
  assert property (@(posedge clk) disable iff (!rst_n_i)
    axi_ar_valid_o && !axi_ar_ready_i |=> axi_ar_valid_o && $stable(axi_ar_addr_o))
    else begin
      proto_errors++;
      $display("ar valid dropped or address changed before ready at cycle %0d", cyc);
    end
  // response is a single-cycle strobe
  assert property (@(posedge clk) disable iff (!rst_n_i) rsp_valid_o |=> !rsp_valid_o)
    else begin
      proto_errors++;
      $display("response valid held longer than one cycle at cycle %0d", cyc);
    end
  assert property (@(posedge clk) disable iff (!rst_n_i) rsp_valid_o |-> outstanding)
    else begin
      proto_errors++;
      $display("response without an accepted request at cycle %0d", cyc);
    end
  // no second request taken while one is in flight
  assert property (@(posedge clk) disable iff (!rst_n_i) outstanding |-> !req_ready_o)
    else begin
      proto_errors++;
      $display("request ready raised before the response at cycle %0d", cyc);
    end

  initial begin
    wait (cyc > 200 * (issued + 1));
    $display("timeout, no response within 200 cycles of request %0d", issued);
    $display("TEST FAILED");
    $finish;
  end

  function automatic mem_path_pkg::data_t ref_word(input mem_path_pkg::addr_t a);
    if (ref_mem.exists(a)) begin
      return ref_mem[a];
    end
    return '0;
  endfunction

  task automatic check_data(input string name, input mem_path_pkg::data_t exp,
                            input mem_path_pkg::data_t act);
    assert (act === exp)
    else begin
      check_errors++;
      $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    assert (act == exp)
    else begin
      check_errors++;
      $display("CHECK FAILED %s expected %0d actual %0d", name, exp, act);
    end
  endtask

  // called right after a rising edge, returns on the response edge
  task automatic issue_request(input mem_path_pkg::addr_t a, input logic we,
                               input mem_path_pkg::data_t d,
                               output mem_path_pkg::data_t rd, output int lat);
    int t_acc;
    issued++;
    req_valid_i <= 1'b1;
    req_addr_i <= a;
    req_we_i <= we;
    req_wdata_i <= d;
    do @(posedge clk); while (!req_ready_o);
    t_acc = cyc;
    req_valid_i <= 1'b0;
    do @(posedge clk); while (!rsp_valid_o);
    rd = rsp_rdata_o;
    lat = cyc - t_acc;
  endtask

  task automatic write_and_check(input string name, input mem_path_pkg::addr_t a);
    mem_path_pkg::data_t d;
    mem_path_pkg::data_t rd;
    int lat;
    int ar_before;
    int aw_before;
    int w_before;
    d = {$urandom, $urandom};
    ar_before = ar_seen;
    aw_before = aw_seen;
    w_before = w_seen;
    ref_mem[a] = d;
    issue_request(a, 1'b1, d, rd, lat);
    // every write reaches the bus, cached or not
    check_count({name, " aw count"}, 1, aw_seen - aw_before);
    check_count({name, " w count"}, 1, w_seen - w_before);
    check_count({name, " ar count"}, 0, ar_seen - ar_before);
    check_data({name, " aw addr"}, {32'h0, a}, {32'h0, aw_addr_seen});
    check_data({name, " w data"}, d, w_data_seen);
  endtask

  // exp_lat below zero skips the latency check
  task automatic read_and_check(input string name, input mem_path_pkg::addr_t a,
                                input int exp_ar, input int exp_lat);
    mem_path_pkg::data_t rd;
    int lat;
    int ar_before;
    ar_before = ar_seen;
    issue_request(a, 1'b0, '0, rd, lat);
    check_data({name, " data"}, ref_word(a), rd);
    check_count({name, " ar count"}, exp_ar, ar_seen - ar_before);
    if (exp_ar > 0) begin
      check_data({name, " ar addr"}, {32'h0, a}, {32'h0, ar_addr_seen});
    end
    if (exp_lat >= 0) begin
      check_count({name, " latency"}, exp_lat, lat);
    end
  endtask

  initial begin
    void'($urandom(98161));
    rst_n_i = 1'b0;
    req_valid_i = 1'b0;
    req_addr_i = '0;
    req_we_i = 1'b0;
    req_wdata_i = '0;
    repeat (5) @(posedge clk);
    rst_n_i <= 1'b1;
    @(posedge clk);

    // core ready high, every axi valid and ready low out of reset
    check_data("reset outputs", 64'h40,
               {57'h0, req_ready_o, rsp_valid_o, axi_aw_valid_o, axi_w_valid_o,
                axi_ar_valid_o, axi_b_ready_o, axi_r_ready_o});

    // below the window, straight to axi
    write_and_check("uncached write", 32'h0000_1000);
    read_and_check("uncached read", 32'h0000_1000, 1, -1);

    // write miss leaves the line empty, so the first read fetches
    write_and_check("window write miss", 32'h8000_0100);
    read_and_check("cached miss", 32'h8000_0100, 1, -1);
    read_and_check("cached hit", 32'h8000_0100, 0, 2);

    // write hit updates the resident line
    write_and_check("write through", 32'h8000_0100);
    read_and_check("read after write", 32'h8000_0100, 0, 2);

    // same index 9, different tags
    write_and_check("conflict write a", 32'h8000_0048);
    write_and_check("conflict write b", 32'h8000_2048);
    for (int i = 0; i < 3; i++) begin
      read_and_check("conflict read a", 32'h8000_0048, 1, -1);
      read_and_check("conflict read b", 32'h8000_2048, 1, -1);
    end

    // window edges
    write_and_check("edge write hi", mem_path_pkg::CACHE_HI);
    write_and_check("edge write past hi", mem_path_pkg::CACHE_HI + 32'd8);
    read_and_check("edge hi miss", mem_path_pkg::CACHE_HI, 1, -1);
    read_and_check("edge hi hit", mem_path_pkg::CACHE_HI, 0, 2);
    read_and_check("edge past hi first", mem_path_pkg::CACHE_HI + 32'd8, 1, -1);
    read_and_check("edge past hi second", mem_path_pkg::CACHE_HI + 32'd8, 1, -1);
    read_and_check("edge below lo first", mem_path_pkg::CACHE_LO - 32'd8, 1, -1);
    read_and_check("edge below lo second", mem_path_pkg::CACHE_LO - 32'd8, 1, -1);

    repeat (3) @(posedge clk);
    $display("errors: check %0d protocol %0d", check_errors, proto_errors);
    if (check_errors == 0 && proto_errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== mem_crossbar.f ====
rtl/mem_path_pkg.sv
rtl/mem_req_if.sv
rtl/uncache_router.sv
rtl/dm_cache.sv
rtl/axi_single_master.sv
rtl/mem_crossbar.sv
test/axi_mem_model.sv
test/tb_mem_crossbar.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_mem_crossbar
FILELIST  = mem_crossbar.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qx "TEST OK"

clean:
	rm -rf obj_dir
